//--- logic/nabp_geometry_pkg.sv
`default_nettype none

package nabp_geometry_pkg;

    // raw detector sample, unsigned
    localparam int raw_width = 12;

    // filtered sample, signed
    localparam int filtered_width = 16;

    // sample index, so a line holds at most 256 samples
    localparam int s_width = 8;

    // ramp kernel geometry
    localparam int filter_taps = 5;
    localparam int filter_half = filter_taps / 2;
    localparam int coef_width = 4;

    typedef logic [raw_width-1:0] raw_t;
    typedef logic signed [filtered_width-1:0] filtered_t;
    typedef logic [s_width-1:0] s_t;
    typedef logic signed [coef_width-1:0] coef_t;

    // symmetric, sums to zero
    localparam coef_t filter_kernel [filter_taps] = '{
        -4'sd1,
        -4'sd2,
        4'sd6,
        -4'sd2,
        -4'sd1
    };

endpackage

`default_nettype wire

//--- logic/nabp_control_pkg.sv
`default_nettype none

package nabp_control_pkg;

    // fill controller of one filtered RAM
    typedef enum logic [1:0] {
        ready_s,
        delay_s,
        fill_s
    } fill_state_e;

    // which filtered RAM is currently being filled
    typedef enum logic {
        bank_a,
        bank_b
    } bank_e;

endpackage

`default_nettype wire

//--- logic/fill_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fill_port_if;

    logic fill_kick;
    nabp_geometry_pkg::s_t s_val;
    nabp_geometry_pkg::filtered_t val;
    logic fill_done;

    // filter side, answers an index with a filtered sample
    modport host (input fill_kick, input s_val, output val);

    // filtered RAM side, walks the index and writes val
    modport ram (input fill_kick, input val, output s_val, output fill_done);

    // swapper view of one filtered RAM
    modport router (output fill_kick, output val, input s_val, input fill_done);

endinterface

`default_nettype wire

//--- logic/processing_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface processing_port_if;

    nabp_geometry_pkg::s_t pr0_s_val;
    nabp_geometry_pkg::s_t pr1_s_val;
    nabp_geometry_pkg::filtered_t pr0_val;
    nabp_geometry_pkg::filtered_t pr1_val;

    // processing engine side
    modport reader (output pr0_s_val, output pr1_s_val, input pr0_val, input pr1_val);

    // filtered RAM side, data one clock after the address
    modport ram (input pr0_s_val, input pr1_s_val, output pr0_val, output pr1_val);

    // swapper view of one filtered RAM
    modport router (output pr0_s_val, output pr1_s_val, input pr0_val, input pr1_val);

endinterface

`default_nettype wire

//--- logic/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter int depth = 32
)
(
    input logic clk,
    input logic we_0,
    input logic we_1,
    input nabp_geometry_pkg::s_t addr_0,
    input nabp_geometry_pkg::s_t addr_1,
    input nabp_geometry_pkg::filtered_t data_in_0,
    input nabp_geometry_pkg::filtered_t data_in_1,
    output nabp_geometry_pkg::filtered_t data_out_0,
    output nabp_geometry_pkg::filtered_t data_out_1
);

    // only the low address bits select a word
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    nabp_geometry_pkg::filtered_t mem [0:(2**aw)-1];

    // read-before-write on both ports
    always_ff @(posedge clk)
    begin
        if (we_0)
        begin
            mem[addr_0[aw-1:0]] <= data_in_0;
        end
        if (we_1)
        begin
            mem[addr_1[aw-1:0]] <= data_in_1;
        end
        data_out_0 <= mem[addr_0[aw-1:0]];
        data_out_1 <= mem[addr_1[aw-1:0]];
    end

endmodule

`default_nettype wire

//--- logic/line_filter.sv
`timescale 1ns/1ps
`default_nettype none

module line_filter #(
    parameter int line_size = 32
)
(
    input logic clk,
    input logic reset_n,
    input logic load_en,
    input nabp_geometry_pkg::s_t load_addr,
    input nabp_geometry_pkg::raw_t load_data,
    fill_port_if.host fill
);

    localparam int taps_n = nabp_geometry_pkg::filter_taps;
    localparam nabp_geometry_pkg::s_t last_idx = nabp_geometry_pkg::s_t'(line_size - 1);

    nabp_geometry_pkg::s_t rd_idx;
    nabp_geometry_pkg::filtered_t raw_ext;
    nabp_geometry_pkg::filtered_t head;
    nabp_geometry_pkg::filtered_t taps [1:taps_n-1];
    nabp_geometry_pkg::filtered_t sum;

    // past the end we keep reading the last sample
    assign rd_idx = (fill.s_val > last_idx) ? last_idx : fill.s_val;

    // raw samples are unsigned
    assign raw_ext = nabp_geometry_pkg::filtered_t'(load_data);

    dual_port_ram #(
        .depth(line_size)
    ) raw_store (
        .clk(clk),
        .we_0(load_en),
        .we_1(1'b0),
        .addr_0(load_addr),
        .addr_1(rd_idx),
        .data_in_0(raw_ext),
        .data_in_1('0),
        .data_out_0(),
        .data_out_1(head)
    );

    // head is the newest sample, taps hold older ones
    // cleared on kick so the left edge sees zeros
    always_ff @(posedge clk)
    begin
        if (reset_n || fill.fill_kick)
        begin
            for (int i = 1; i < taps_n; i++)
            begin
                taps[i] <= '0;
            end
        end
        else
        begin
            taps[1] <= head;
            for (int i = 2; i < taps_n; i++)
            begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // centre sample sits in taps[filter_half]
    always_comb
    begin
        sum = head * nabp_geometry_pkg::filtered_t'(nabp_geometry_pkg::filter_kernel[0]);
        for (int i = 1; i < taps_n; i++)
        begin
            sum = sum + taps[i]
                * nabp_geometry_pkg::filtered_t'(nabp_geometry_pkg::filter_kernel[i]);
        end
    end

    assign fill.val = sum;

endmodule

`default_nettype wire

//--- logic/filtered_ram_swappable.sv
`timescale 1ns/1ps
`default_nettype none

module filtered_ram_swappable #(
    parameter int line_size = 32
)
(
    input logic clk,
    input logic reset_n,
    fill_port_if.ram fill,
    processing_port_if.ram proc
);

    localparam nabp_geometry_pkg::s_t last_idx = nabp_geometry_pkg::s_t'(line_size - 1);
    localparam nabp_geometry_pkg::s_t delay_last =
        nabp_geometry_pkg::s_t'(nabp_geometry_pkg::filter_half);
    localparam int lead = nabp_geometry_pkg::filter_half + 1;

    nabp_control_pkg::fill_state_e state;
    nabp_control_pkg::fill_state_e next_state;
    nabp_geometry_pkg::s_t read_itr;
    nabp_geometry_pkg::s_t write_itr;
    nabp_geometry_pkg::s_t port0_addr;
    logic write_en;
    logic delay_done;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= nabp_control_pkg::ready_s;
        else
            state <= next_state;
    end

    // index 0 is read in the kick cycle, so the read side
    // is filter_half + 1 ahead of the write side once filling
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            read_itr <= '0;
            write_itr <= '0;
        end
        else
        begin
            unique case (state)
                nabp_control_pkg::ready_s:
                begin
                    write_itr <= '0;
                    read_itr <= fill.fill_kick ? nabp_geometry_pkg::s_t'(1) : '0;
                end
                nabp_control_pkg::delay_s:
                    read_itr <= read_itr + 1'b1;
                nabp_control_pkg::fill_s:
                begin
                    if (next_state == nabp_control_pkg::ready_s)
                    begin
                        read_itr <= '0;
                        write_itr <= '0;
                    end
                    else
                    begin
                        write_itr <= write_itr + 1'b1;
                        // saturate, the filter replicates the last sample
                        if (read_itr != last_idx)
                            read_itr <= read_itr + 1'b1;
                    end
                end
                default:
                    read_itr <= '0;
            endcase
        end
    end

    assign delay_done = (read_itr == delay_last);

    always_comb
    begin
        next_state = state;
        unique case (state)
            nabp_control_pkg::ready_s:
                if (fill.fill_kick)
                    next_state = nabp_control_pkg::delay_s;
            nabp_control_pkg::delay_s:
                if (delay_done)
                    next_state = nabp_control_pkg::fill_s;
            nabp_control_pkg::fill_s:
                if (write_itr == last_idx)
                    next_state = nabp_control_pkg::ready_s;
            default:
                next_state = nabp_control_pkg::ready_s;
        endcase
    end

    // pulse in the cycle of the last write
    assign fill.fill_done = (state == nabp_control_pkg::fill_s)
        && (next_state == nabp_control_pkg::ready_s);
    assign fill.s_val = read_itr;
    assign write_en = (state == nabp_control_pkg::fill_s);

    // port 0 belongs to the fill while not ready
    assign port0_addr = (state == nabp_control_pkg::ready_s) ? proc.pr0_s_val : write_itr;

    dual_port_ram #(
        .depth(line_size)
    ) filtered_store (
        .clk(clk),
        .we_0(write_en),
        .we_1(1'b0),
        .addr_0(port0_addr),
        .addr_1(proc.pr1_s_val),
        .data_in_0(fill.val),
        .data_in_1('0),
        .data_out_0(proc.pr0_val),
        .data_out_1(proc.pr1_val)
    );

    // read side leads by filter_half + 1 and stops at the line end
    a_iter_lead: assert property (@(posedge clk) disable iff (reset_n)
        state == nabp_control_pkg::fill_s
            |-> int'(read_itr) == ((int'(write_itr) + lead > int'(last_idx))
                ? int'(last_idx) : int'(write_itr) + lead))
        else $error("read iterator out of step with the write iterator");

    // a new kick must wait for the previous fill_done
    a_kick_when_ready: assert property (@(posedge clk) disable iff (reset_n)
        fill.fill_kick |-> state == nabp_control_pkg::ready_s)
        else $error("fill kick while a fill is running");

endmodule

`default_nettype wire

//--- logic/bank_swapper.sv
`timescale 1ns/1ps
`default_nettype none

module bank_swapper
(
    input logic clk,
    input logic reset_n,
    input logic swap,
    output nabp_control_pkg::bank_e fill_bank,
    fill_port_if.ram host,
    fill_port_if.router bank_a_fill,
    fill_port_if.router bank_b_fill,
    processing_port_if.ram reader,
    processing_port_if.router bank_a_proc,
    processing_port_if.router bank_b_proc
);

    nabp_control_pkg::bank_e bank_q;
    logic busy;
    logic fill_on_a;

    // a fill runs from kick to done, swaps in between are dropped
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            bank_q <= nabp_control_pkg::bank_a;
            busy <= 1'b0;
        end
        else
        begin
            if (host.fill_kick)
                busy <= 1'b1;
            else if (host.fill_done)
                busy <= 1'b0;
            if (swap && !busy && !host.fill_kick)
                bank_q <= (bank_q == nabp_control_pkg::bank_a)
                    ? nabp_control_pkg::bank_b : nabp_control_pkg::bank_a;
        end
    end

    assign fill_bank = bank_q;
    assign fill_on_a = (bank_q == nabp_control_pkg::bank_a);

    // fill side goes to the fill bank
    assign bank_a_fill.fill_kick = fill_on_a && host.fill_kick;
    assign bank_b_fill.fill_kick = !fill_on_a && host.fill_kick;
    assign bank_a_fill.val = host.val;
    assign bank_b_fill.val = host.val;
    assign host.s_val = fill_on_a ? bank_a_fill.s_val : bank_b_fill.s_val;
    assign host.fill_done = fill_on_a ? bank_a_fill.fill_done : bank_b_fill.fill_done;

    // processing side reads the other bank
    assign bank_a_proc.pr0_s_val = fill_on_a ? '0 : reader.pr0_s_val;
    assign bank_a_proc.pr1_s_val = fill_on_a ? '0 : reader.pr1_s_val;
    assign bank_b_proc.pr0_s_val = fill_on_a ? reader.pr0_s_val : '0;
    assign bank_b_proc.pr1_s_val = fill_on_a ? reader.pr1_s_val : '0;
    assign reader.pr0_val = fill_on_a ? bank_b_proc.pr0_val : bank_a_proc.pr0_val;
    assign reader.pr1_val = fill_on_a ? bank_b_proc.pr1_val : bank_a_proc.pr1_val;

    a_swap_when_idle: assert property (@(posedge clk) disable iff (reset_n)
        swap |-> !busy && !host.fill_kick)
        else $error("swap requested during a fill, ignored");

endmodule

`default_nettype wire

//--- logic/filtered_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module filtered_line_buffer #(
    parameter int line_size = 32
)
(
    input logic clk,
    input logic reset_n,
    input logic load_en,
    input nabp_geometry_pkg::s_t load_addr,
    input nabp_geometry_pkg::raw_t load_data,
    input logic fill_kick,
    output logic fill_done,
    input logic swap,
    output nabp_control_pkg::bank_e fill_bank,
    input nabp_geometry_pkg::s_t pr0_s_val,
    input nabp_geometry_pkg::s_t pr1_s_val,
    output nabp_geometry_pkg::filtered_t pr0_val,
    output nabp_geometry_pkg::filtered_t pr1_val
);

    fill_port_if host_fill ();
    fill_port_if bank_a_fill ();
    fill_port_if bank_b_fill ();
    processing_port_if reader_proc ();
    processing_port_if bank_a_proc ();
    processing_port_if bank_b_proc ();

    // host pulses and processing addresses
    assign host_fill.fill_kick = fill_kick;
    assign fill_done = host_fill.fill_done;
    assign reader_proc.pr0_s_val = pr0_s_val;
    assign reader_proc.pr1_s_val = pr1_s_val;
    assign pr0_val = reader_proc.pr0_val;
    assign pr1_val = reader_proc.pr1_val;

    line_filter #(
        .line_size(line_size)
    ) u_line_filter (
        .clk(clk),
        .reset_n(reset_n),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .fill(host_fill)
    );

    bank_swapper u_bank_swapper (
        .clk(clk),
        .reset_n(reset_n),
        .swap(swap),
        .fill_bank(fill_bank),
        .host(host_fill),
        .bank_a_fill(bank_a_fill),
        .bank_b_fill(bank_b_fill),
        .reader(reader_proc),
        .bank_a_proc(bank_a_proc),
        .bank_b_proc(bank_b_proc)
    );

    filtered_ram_swappable #(
        .line_size(line_size)
    ) u_bank_a (
        .clk(clk),
        .reset_n(reset_n),
        .fill(bank_a_fill),
        .proc(bank_a_proc)
    );

    filtered_ram_swappable #(
        .line_size(line_size)
    ) u_bank_b (
        .clk(clk),
        .reset_n(reset_n),
        .fill(bank_b_fill),
        .proc(bank_b_proc)
    );

endmodule

`default_nettype wire

//--- tests/filtered_line_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module filtered_line_buffer_tb;

    localparam int line_size = 32;
    localparam int n_records = 6;
    localparam int done_timeout = 4 * line_size;

    // pat_keep loads nothing, the record only swaps
    typedef enum int {pat_ramp, pat_constant, pat_impulse, pat_random, pat_keep} pattern_e;

    typedef struct packed {
        pattern_e kind;
        logic swap_after;
    } line_rec_t;

    logic clk;
    logic reset_n;
    logic load_en;
    nabp_geometry_pkg::s_t load_addr;
    nabp_geometry_pkg::raw_t load_data;
    logic fill_kick;
    logic fill_done;
    logic swap;
    nabp_control_pkg::bank_e fill_bank;
    nabp_geometry_pkg::s_t pr0_s_val;
    nabp_geometry_pkg::s_t pr1_s_val;
    nabp_geometry_pkg::filtered_t pr0_val;
    nabp_geometry_pkg::filtered_t pr1_val;

    line_rec_t line_table [0:n_records-1];
    int raw_line [0:line_size-1];
    // expected contents of bank a (0) and bank b (1)
    int bank_model [0:1][0:line_size-1];
    pattern_e bank_kind [0:1];
    bit bank_valid [0:1] = '{1'b0, 1'b0};
    int model_bank = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int kicks = 0;
    int done_pulses = 0;
    bit aborted = 1'b0;

    filtered_line_buffer #(
        .line_size(line_size)
    ) UUT (
        .clk(clk),
        .reset_n(reset_n),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .fill_kick(fill_kick),
        .fill_done(fill_done),
        .swap(swap),
        .fill_bank(fill_bank),
        .pr0_s_val(pr0_s_val),
        .pr1_s_val(pr1_s_val),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val)
    );

    always #10 clk = ~clk;

    // every high cycle of fill_done counts as one pulse
    always @(negedge clk)
    begin
        if (fill_done === 1'b1)
            done_pulses++;
    end

    // zero before the line, last sample repeated after it
    function automatic int raw_at(int j);
        if (j < 0)
            return 0;
        if (j > line_size - 1)
            return raw_line[line_size-1];
        return raw_line[j];
    endfunction

    function automatic int filter_model(int idx);
        int acc;
        acc = 0;
        for (int k = 0; k < nabp_geometry_pkg::filter_taps; k++)
        begin
            acc += int'(nabp_geometry_pkg::filter_kernel[k])
                * raw_at(idx + k - nabp_geometry_pkg::filter_half);
        end
        return acc;
    endfunction

    task automatic make_line(input pattern_e kind);
        for (int i = 0; i < line_size; i++)
        begin
            case (kind)
                pat_ramp: raw_line[i] = 64 * i + 5;
                pat_constant: raw_line[i] = 3000;
                pat_impulse: raw_line[i] = (i == 0 || i == line_size - 1) ? 2047 : 0;
                default: raw_line[i] = int'($urandom() & 32'hfff);
            endcase
        end
    endtask

    task automatic load_line();
        for (int i = 0; i < line_size; i++)
        begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= nabp_geometry_pkg::s_t'(i);
            load_data <= nabp_geometry_pkg::raw_t'(raw_line[i]);
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // one kick, then wait for the done pulse
    task automatic run_fill(output bit ok);
        ok = 1'b0;
        @(posedge clk);
        fill_kick <= 1'b1;
        kicks++;
        @(posedge clk);
        fill_kick <= 1'b0;
        for (int cyc = 0; cyc < done_timeout && !ok; cyc++)
        begin
            @(negedge clk);
            if (fill_done === 1'b1)
                ok = 1'b1;
        end
        if (!ok)
            $display("timeout: no fill_done within %0d cycles of the kick", done_timeout);
    endtask

    task automatic swap_banks();
        @(posedge clk);
        swap <= 1'b1;
        @(posedge clk);
        swap <= 1'b0;
        model_bank = 1 - model_bank;
    endtask

    task automatic check_sample(input string port, input int idx,
                                input nabp_geometry_pkg::filtered_t got, input int exp);
        assert (got === nabp_geometry_pkg::filtered_t'(exp))
        else
        begin
            errors++;
            $display("MISMATCH at %0d ns: %s index %0d read %0d, expected %0d",
                     $time, port, idx, got, exp);
        end
    endtask

    // pr0 walks up, pr1 walks down, data one cycle behind the address
    task automatic read_back();
        int pb;
        int idx0;
        int idx1;
        pb = 1 - model_bank;
        @(negedge clk);
        assert (fill_bank === (model_bank == 0 ? nabp_control_pkg::bank_a
                                                : nabp_control_pkg::bank_b))
        else
        begin
            errors++;
            $display("MISMATCH at %0d ns: fill_bank is %0d, expected %0d",
                     $time, fill_bank, model_bank);
        end
        for (int i = 0; i <= line_size && bank_valid[pb]; i++)
        begin
            @(posedge clk);
            if (i < line_size)
            begin
                pr0_s_val <= nabp_geometry_pkg::s_t'(i);
                pr1_s_val <= nabp_geometry_pkg::s_t'(line_size - 1 - i);
            end
            @(negedge clk);
            if (i > 0)
            begin
                idx0 = i - 1;
                idx1 = line_size - i;
                check_sample("pr0", idx0, pr0_val, bank_model[pb][idx0]);
                check_sample("pr1", idx1, pr1_val, bank_model[pb][idx1]);
                // a flat line only leaves a trace at the zero padded edge
                if (bank_kind[pb] == pat_constant && idx0 >= nabp_geometry_pkg::filter_half)
                    check_sample("pr0 flat", idx0, pr0_val, 0);
            end
        end
    endtask

    initial
    begin
        bit ok;
        int errors_before;
        pattern_e kind;
        clk = 1'b0;
        reset_n = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        fill_kick = 1'b0;
        swap = 1'b0;
        pr0_s_val = '0;
        pr1_s_val = '0;
        void'($urandom(47867));
        line_table[0] = '{pat_ramp, 1'b1};
        line_table[1] = '{pat_impulse, 1'b1};
        line_table[2] = '{pat_random, 1'b0};
        line_table[3] = '{pat_keep, 1'b1};
        line_table[4] = '{pat_constant, 1'b1};
        line_table[5] = '{pat_random, 1'b1};

        repeat (16) @(posedge clk);
        reset_n <= 1'b0;
        @(negedge clk);
        errors_before = errors;
        assert (fill_done === 1'b0)
        else
        begin
            errors++;
            $display("MISMATCH at %0d ns: fill_done high after reset", $time);
        end
        assert (fill_bank === nabp_control_pkg::bank_a)
        else
        begin
            errors++;
            $display("MISMATCH at %0d ns: fill_bank is %0d after reset", $time, fill_bank);
        end
        tests_run++;
        if (errors != errors_before)
            tests_failed++;
        $display("test 0 reset: %s", (errors == errors_before) ? "ok" : "failed");

        for (int rec = 0; rec < n_records && !aborted; rec++)
        begin
            errors_before = errors;
            kind = line_table[rec].kind;
            if (kind != pat_keep)
            begin
                make_line(kind);
                load_line();
                run_fill(ok);
                aborted = !ok;
                for (int i = 0; i < line_size; i++)
                    bank_model[model_bank][i] = filter_model(i);
                bank_kind[model_bank] = kind;
                bank_valid[model_bank] = 1'b1;
            end
            if (!aborted && line_table[rec].swap_after)
                swap_banks();
            if (!aborted)
                read_back();
            tests_run++;
            if (aborted || errors != errors_before)
                tests_failed++;
            $display("test %0d %s: %s", rec + 1, kind.name(),
                     (!aborted && errors == errors_before) ? "ok" : "failed");
        end

        // quiet period, a stray done pulse would show up here
        repeat (8) @(posedge clk);
        errors_before = errors;
        assert (done_pulses == kicks)
        else
        begin
            errors++;
            $display("MISMATCH at %0d ns: %0d fill_done pulses for %0d kicks",
                     $time, done_pulses, kicks);
        end
        tests_run++;
        if (errors != errors_before)
            tests_failed++;
        $display("test %0d done count: %s", n_records + 1,
                 (errors == errors_before) ? "ok" : "failed");

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && !aborted)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filtered_line_buffer.f
logic/nabp_geometry_pkg.sv
logic/nabp_control_pkg.sv
logic/fill_port_if.sv
logic/processing_port_if.sv
logic/dual_port_ram.sv
logic/line_filter.sv
logic/filtered_ram_swappable.sv
logic/bank_swapper.sv
logic/filtered_line_buffer.sv
tests/filtered_line_buffer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the line buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module filtered_line_buffer_tb -Mdir obj_dir -o sim_tb \
    -f filtered_line_buffer.f > obj_dir/build.log 2>&1 \
    && ./obj_dir/sim_tb > obj_dir/sim.log 2>&1 \
    || { cat obj_dir/build.log obj_dir/sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
cat obj_dir/sim.log
grep -q "CHECKS FAILED" obj_dir/sim.log && { echo "result: fail"; exit 1; } \
    || { echo "result: pass"; exit 0; }
